/* project.f */
verilog/memBusPkg.sv
verilog/coherencePkg.sv
verilog/requestArbiter.sv
verilog/snoopStage.sv
verilog/memorySequencer.sv
verilog/busController.sv
sim/busController_sva.sv
sim/busController_tb.sv

/* run.sh */
#!/bin/sh
# build and run the bus controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module busController_tb \
    -f project.f \
    -o busController_sim > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/busController_sim > sim.log 2>&1
runStatus=$?
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus, see sim.log"
fi

if grep -q "^TB PASSED$" sim.log; then
    if [ $runStatus -ne 0 ]; then
        exit 1
    fi
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* sim/busController_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module busController_tb;
    import memBusPkg::*;
    import coherencePkg::*;

    localparam int nTxn = 200;
    localparam int txnCycles = 20;
    localparam int resetCycles = 16;
    localparam int cycleLimit = nTxn * txnCycles + resetCycles;
    localparam int memWords = 64;

    logic      CLK;
    logic      nRST;
    coreReq_t  coreReqs [nCores];
    coreResp_t coreResps [nCores];
    ramReq_t   ramReq;
    ramResp_t  ramResp;

    // RAM contents and the scoreboard copy
    word_t     ramMem [memWords];
    word_t     expMem [memWords];
    logic      ramPending;
    int        latLeft;
    // request intent per core where dMode is 0 none, 1 read, 2 read-exclusive or 3 write-back
    logic      iOn [nCores];
    word_t     iAddr [nCores];
    int        dMode [nCores];
    word_t     dAddr [nCores];
    word_t     dStore [nCores];
    // transaction in flight as the model expects it
    logic      txnActive;
    int        txnCore;
    busOp_e    txnOp;
    word_t     txnAddr;
    logic      snoopSeen;
    logic      ansHit;
    logic      ansMod;
    word_t     wbWord0;
    word_t     wbWord1;
    ramReq_t   expRam [$];
    int        doneCount;
    int        cycleCount;
    int        errorCount;
    logic      running;

    busController uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .coreReqs  (coreReqs),
        .coreResps (coreResps),
        .ramReq    (ramReq),
        .ramResp   (ramResp)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    task automatic failValue(input string msg);
        errorCount++;
        $display("FAIL %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic failPlain(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkRamReq(input ramReq_t expReq, input ramReq_t actReq);
        if (actReq !== expReq) begin
            failValue($sformatf("ramReq expected %h got %h", expReq, actReq));
        end
    endtask

    task automatic checkLoad(input string what, input word_t expWord, input word_t actWord);
        if (actWord !== expWord) begin
            failValue($sformatf("%s expected %h got %h", what, expWord, actWord));
        end
    endtask

    task automatic checkCoreFlags(input int core, input coreResp_t expResp,
                                  input coreResp_t actResp, input logic ccwaitFree);
        if (actResp.iwait !== expResp.iwait || actResp.dwait !== expResp.dwait ||
            actResp.ccinv !== expResp.ccinv ||
            (!ccwaitFree && actResp.ccwait !== expResp.ccwait)) begin
            failValue($sformatf("core %0d wait/inv flags expected %b%b%b%b got %b%b%b%b",
                core, expResp.iwait, expResp.dwait, expResp.ccwait, expResp.ccinv,
                actResp.iwait, actResp.dwait, actResp.ccwait, actResp.ccinv));
        end
    endtask

    function automatic int wordIndex(input word_t addr);
        return int'(addr[7:2]);
    endfunction

    function automatic word_t blockBase(input word_t addr);
        return {addr[31:3], 1'b0, addr[1:0]};
    endfunction

    function automatic word_t randAddr();
        return word_t'($urandom_range(memWords - 1, 0)) << 2;
    endfunction

    function automatic ramReq_t ramAccess(input logic write, input word_t addr, input word_t data);
        ramReq_t req;
        req = '0;
        req.ramREN = !write;
        req.ramWEN = write;
        req.ramaddr = addr;
        req.ramstore = write ? data : '0;
        return req;
    endfunction

    // priority: dREN 0, dREN 1, dWEN 0, dWEN 1, iREN 0, iREN 1
    task automatic pickRequest();
        int     winner;
        int     c;
        busOp_e kind;
        word_t  addr;
        word_t  store;
        winner = -1;
        kind = IFETCH;
        addr = '0;
        store = '0;
        for (int src = 0; src < 3 * nCores; src++) begin
            c = src % nCores;
            if (winner < 0) begin
                if (src < nCores && coreReqs[c].dREN) begin
                    winner = c;
                    kind = coreReqs[c].ccwrite ? BUSRDX : BUSRD;
                    addr = coreReqs[c].daddr;
                end else if (src >= nCores && src < 2 * nCores && coreReqs[c].dWEN) begin
                    winner = c;
                    kind = DWRITEBACK;
                    addr = coreReqs[c].daddr;
                    store = coreReqs[c].dstore;
                end else if (src >= 2 * nCores && coreReqs[c].iREN) begin
                    winner = c;
                    kind = IFETCH;
                    addr = coreReqs[c].iaddr;
                end
            end
        end
        if (winner >= 0) begin
            txnActive = 1'b1;
            txnCore = winner;
            txnOp = kind;
            txnAddr = addr;
            snoopSeen = 1'b0;
            expRam.delete();
            if (kind == BUSRD || kind == BUSRDX) begin
                // peer answer chosen up front
                ansHit = 1'($urandom_range(1, 0));
                ansMod = 1'($urandom_range(1, 0));
                wbWord0 = word_t'($urandom);
                wbWord1 = word_t'($urandom);
                if (ansHit && ansMod) begin
                    expRam.push_back(ramAccess(1'b1, blockBase(addr), wbWord0));
                    expRam.push_back(ramAccess(1'b1, blockBase(addr) + 32'd4, wbWord1));
                end
            end
            expRam.push_back(ramAccess(kind == DWRITEBACK, addr, store));
        end
    endtask

    task automatic busCycle();
        logic      accessNow;
        logic      completing;
        logic      wasIdle;
        logic      snoopOp;
        int        peer;
        coreResp_t expResp;
        ramReq_t   headReq;
        wasIdle = !txnActive;
        accessNow = (ramResp.ramstate == ACCESS);
        completing = 1'b0;
        peer = 1 - txnCore;
        snoopOp = txnActive && (txnOp == BUSRD || txnOp == BUSRDX);
        if (accessNow) begin
            if (expRam.size() == 0) begin
                failPlain("RAM reached ACCESS while no access was expected");
            end else begin
                headReq = expRam.pop_front();
                checkRamReq(headReq, ramReq);
                if (headReq.ramWEN) begin
                    expMem[wordIndex(headReq.ramaddr)] = headReq.ramstore;
                end
                completing = (expRam.size() == 0);
            end
        end
        for (int c = 0; c < nCores; c++) begin
            expResp = '0;
            expResp.iwait = coreReqs[c].iREN;
            expResp.dwait = coreReqs[c].dREN || coreReqs[c].dWEN;
            if (completing && c == txnCore) begin
                if (txnOp == IFETCH) begin
                    expResp.iwait = 1'b0;
                end else begin
                    expResp.dwait = 1'b0;
                end
            end
            expResp.ccinv = completing && c == peer && txnOp == BUSRDX;
            // peer stays in wait from the first probe cycle until completion
            if (snoopOp && c == peer) begin
                expResp.ccwait = snoopSeen;
            end
            checkCoreFlags(c, expResp, coreResps[c], snoopOp && c == peer && !snoopSeen);
        end
        if (snoopOp && !snoopSeen && coreResps[peer].ccwait) begin
            snoopSeen = 1'b1;
            checkLoad("ccsnoopaddr", blockBase(txnAddr), coreResps[peer].ccsnoopaddr);
        end
        if (completing) begin
            if (snoopOp && !snoopSeen) begin
                failPlain("data read finished without a snoop of the peer cache");
            end
            if (txnOp == IFETCH) begin
                checkLoad("iload", expMem[wordIndex(txnAddr)], coreResps[txnCore].iload);
                iOn[txnCore] = 1'b0;
            end else begin
                if (txnOp != DWRITEBACK) begin
                    checkLoad("dload", expMem[wordIndex(txnAddr)], coreResps[txnCore].dload);
                end
                dMode[txnCore] = 0;
            end
            txnActive = 1'b0;
            doneCount++;
        end
        // RAM with 1 to 4 cycles of latency
        if (accessNow) begin
            if (ramReq.ramWEN) begin
                ramMem[wordIndex(ramReq.ramaddr)] = ramReq.ramstore;
            end
            ramPending = 1'b0;
            ramResp.ramstate <= FREE;
        end else if (ramReq.ramREN || ramReq.ramWEN) begin
            if (!ramPending) begin
                ramPending = 1'b1;
                latLeft = int'($urandom_range(4, 1));
            end
            latLeft--;
            if (latLeft == 0) begin
                ramResp.ramstate <= ACCESS;
                ramResp.ramload <= ramMem[wordIndex(ramReq.ramaddr)];
            end else begin
                ramResp.ramstate <= BUSY;
            end
        end
        if (wasIdle) begin
            pickRequest();
        end
    endtask

    task automatic driveCores();
        coreReq_t nxt;
        int       other;
        logic     ending;
        for (int c = 0; c < nCores; c++) begin
            if (!iOn[c] && $urandom_range(1, 0) == 1) begin
                iOn[c] = 1'b1;
                iAddr[c] = randAddr();
            end
            if (dMode[c] == 0 && $urandom_range(1, 0) == 1) begin
                dMode[c] = int'($urandom_range(3, 1));
                dAddr[c] = randAddr();
                dStore[c] = word_t'($urandom);
            end
        end
        for (int c = 0; c < nCores; c++) begin
            other = 1 - c;
            nxt = '0;
            nxt.iREN = iOn[c];
            nxt.iaddr = iAddr[c];
            nxt.dREN = (dMode[c] == 1) || (dMode[c] == 2);
            nxt.dWEN = (dMode[c] == 3);
            nxt.ccwrite = (dMode[c] == 2);
            nxt.daddr = dAddr[c];
            nxt.dstore = dStore[c];
            // snooped cache answers and follows the snoop address until the read ends
            ending = coreReqs[other].dREN && !coreResps[other].dwait;
            if (coreResps[c].ccwait && !ending) begin
                nxt.cctrans = ansHit;
                nxt.ccwrite = ansMod;
                nxt.daddr = coreResps[c].ccsnoopaddr;
                nxt.dstore = coreResps[c].ccsnoopaddr[2] ? wbWord1 : wbWord0;
            end
            coreReqs[c] <= nxt;
        end
    endtask

    always @(posedge CLK) begin
        if (running) begin
            busCycle();
            driveCores();
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            failPlain($sformatf("timeout after %0d cycles with %0d transactions done",
                cycleCount, doneCount));
        end
    end

    initial begin
        void'($urandom(32'h968a99fc));
        nRST = 1'b0;
        running = 1'b0;
        txnActive = 1'b0;
        txnCore = 0;
        txnOp = IFETCH;
        txnAddr = '0;
        snoopSeen = 1'b0;
        ansHit = 1'b0;
        ansMod = 1'b0;
        wbWord0 = '0;
        wbWord1 = '0;
        ramPending = 1'b0;
        latLeft = 0;
        doneCount = 0;
        cycleCount = 0;
        errorCount = 0;
        ramResp.ramload = '0;
        ramResp.ramstate = FREE;
        for (int c = 0; c < nCores; c++) begin
            coreReqs[c] = '0;
            iOn[c] = 1'b0;
            iAddr[c] = '0;
            dMode[c] = 0;
            dAddr[c] = '0;
            dStore[c] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            ramMem[i] = word_t'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
            expMem[i] = ramMem[i];
        end
        repeat (resetCycles) @(posedge CLK);
        nRST <= 1'b1;
        running <= 1'b1;
        wait (doneCount >= nTxn);
        @(posedge CLK);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/busController_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module busController_sva (
    input logic                 CLK,
    input logic                 nRST,
    input memBusPkg::ramReq_t   ramReq,
    input memBusPkg::coreResp_t coreResps [memBusPkg::nCores],
    input coherencePkg::grant_t grant,
    input logic                 done
);
    import memBusPkg::*;

    logic anyInv;
    logic invUnpaired;

    always_comb begin
        anyInv = 1'b0;
        invUnpaired = 1'b0;
        for (int i = 0; i < nCores; i++) begin
            anyInv = anyInv || coreResps[i].ccinv;
            // the requester is the other core
            if (coreResps[i].ccinv && coreResps[nCores - 1 - i].dwait) begin
                invUnpaired = 1'b1;
            end
        end
    end

    // single port RAM
    noReadAndWrite: assert property (@(posedge CLK) disable iff (!nRST)
        !(ramReq.ramREN && ramReq.ramWEN))
        else $error("ramREN and ramWEN high together");

    // invalidate only alongside the requester's data completion
    invWithCompletion: assert property (@(posedge CLK) disable iff (!nRST)
        anyInv |-> (done && !invUnpaired))
        else $error("ccinv high outside the requester completion");

    grantHeld: assert property (@(posedge CLK) disable iff (!nRST)
        (grant.valid && !done) |=> $stable(grant))
        else $error("grant changed before done");

endmodule

bind busController busController_sva protocolChecks (
    .CLK       (CLK),
    .nRST      (nRST),
    .ramReq    (ramReq),
    .coreResps (coreResps),
    .grant     (grant),
    .done      (done)
);

`default_nettype wire

/* verilog/busController.sv */
`timescale 1ns/1ps
`default_nettype none

module busController (
    input  logic                 CLK,
    input  logic                 nRST,
    input  memBusPkg::coreReq_t  coreReqs [memBusPkg::nCores],
    output memBusPkg::coreResp_t coreResps [memBusPkg::nCores],
    output memBusPkg::ramReq_t   ramReq,
    input  memBusPkg::ramResp_t  ramResp
);
    import memBusPkg::*;
    import coherencePkg::*;

    grant_t       grant;
    snoopResult_t snoop;
    logic         done;
    logic         probeWait [nCores];
    word_t        probeAddr [nCores];

    requestArbiter arbiter (
        .CLK      (CLK),
        .nRST     (nRST),
        .coreReqs (coreReqs),
        .done     (done),
        .grant    (grant)
    );

    snoopStage snooper (
        .CLK       (CLK),
        .nRST      (nRST),
        .grant     (grant),
        .coreReqs  (coreReqs),
        .done      (done),
        .snoop     (snoop),
        .probeWait (probeWait),
        .probeAddr (probeAddr)
    );

    memorySequencer sequencer (
        .CLK       (CLK),
        .nRST      (nRST),
        .snoop     (snoop),
        .probeWait (probeWait),
        .probeAddr (probeAddr),
        .coreReqs  (coreReqs),
        .ramResp   (ramResp),
        .ramReq    (ramReq),
        .coreResps (coreResps),
        .done      (done)
    );

endmodule

`default_nettype wire

/* verilog/memorySequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module memorySequencer (
    input  logic                       CLK,
    input  logic                       nRST,
    input  coherencePkg::snoopResult_t snoop,
    input  logic                       probeWait [memBusPkg::nCores],
    input  memBusPkg::word_t           probeAddr [memBusPkg::nCores],
    input  memBusPkg::coreReq_t        coreReqs [memBusPkg::nCores],
    input  memBusPkg::ramResp_t        ramResp,
    output memBusPkg::ramReq_t         ramReq,
    output memBusPkg::coreResp_t       coreResps [memBusPkg::nCores],
    output logic                       done
);
    import memBusPkg::*;
    import coherencePkg::*;

    seqState_e state;
    logic      ramDone;
    coreIdx_t  owner;
    coreIdx_t  peer;
    busOp_e    op;

    assign ramDone = (ramResp.ramstate == ACCESS);
    assign owner   = snoop.grant.core;
    assign peer    = ~snoop.grant.core;
    assign op      = snoop.grant.op;
    assign done    = (state == TRANSFER) && ramDone;

    // each RAM word holds its state until ACCESS
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (snoop.grant.valid) begin
                        if (snoop.peerModified) begin
                            state <= PEERWB0;
                        end else begin
                            state <= TRANSFER;
                        end
                    end
                end
                PEERWB0: begin
                    if (ramDone) begin
                        state <= PEERWB1;
                    end
                end
                PEERWB1: begin
                    if (ramDone) begin
                        state <= TRANSFER;
                    end
                end
                TRANSFER: begin
                    if (ramDone) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        ramReq = '0;
        case (state)
            PEERWB0, PEERWB1: begin
                // peer cache drives the dirty word for the snoop address
                ramReq.ramWEN   = 1'b1;
                ramReq.ramaddr  = coreReqs[peer].daddr;
                ramReq.ramstore = coreReqs[peer].dstore;
            end
            TRANSFER: begin
                ramReq.ramaddr = snoop.grant.addr;
                if (op == DWRITEBACK) begin
                    ramReq.ramWEN   = 1'b1;
                    ramReq.ramstore = snoop.grant.store;
                end else begin
                    ramReq.ramREN = 1'b1;
                end
            end
            default: begin
                ramReq = '0;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < nCores; i++) begin
            coreResps[i].iload       = ramResp.ramload;
            coreResps[i].dload       = ramResp.ramload;
            // pending requests wait unless completing now
            coreResps[i].iwait       = coreReqs[i].iREN;
            coreResps[i].dwait       = coreReqs[i].dREN || coreReqs[i].dWEN;
            coreResps[i].ccwait      = probeWait[i];
            coreResps[i].ccsnoopaddr = probeAddr[i];
            coreResps[i].ccinv       = 1'b0;
            if (done && (owner == coreIdx_t'(i))) begin
                if (op == IFETCH) begin
                    coreResps[i].iwait = 1'b0;
                end else begin
                    coreResps[i].dwait = 1'b0;
                end
            end
            if (peer == coreIdx_t'(i)) begin
                // second word of the block
                if (state == PEERWB1) begin
                    coreResps[i].ccsnoopaddr = probeAddr[i] + word_t'(wordBytes);
                end
                if (done && (op == BUSRDX)) begin
                    coreResps[i].ccinv = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/snoopStage.sv */
`timescale 1ns/1ps
`default_nettype none

module snoopStage (
    input  logic                       CLK,
    input  logic                       nRST,
    input  coherencePkg::grant_t       grant,
    input  memBusPkg::coreReq_t        coreReqs [memBusPkg::nCores],
    input  logic                       done,
    output coherencePkg::snoopResult_t snoop,
    output logic                       probeWait [memBusPkg::nCores],
    output memBusPkg::word_t           probeAddr [memBusPkg::nCores]
);
    import memBusPkg::*;
    import coherencePkg::*;

    snoopState_e state;
    logic        fwdValid;
    logic        probing;
    logic        peerModified;
    logic        needSnoop;
    coreIdx_t    peer;
    word_t       blockBase;

    assign needSnoop = (grant.op == BUSRD) || (grant.op == BUSRDX);
    assign peer      = ~grant.core;
    // clear the word offset inside the block
    assign blockBase = grant.addr & ~word_t'(wordBytes * (blockWords - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state        <= SNOOP_IDLE;
            fwdValid     <= 1'b0;
            probing      <= 1'b0;
            peerModified <= 1'b0;
        end else begin
            case (state)
                SNOOP_IDLE: begin
                    if (done) begin
                        fwdValid <= 1'b0;
                        probing  <= 1'b0;
                    end else if (grant.valid && !fwdValid) begin
                        if (needSnoop) begin
                            state   <= PROBE;
                            probing <= 1'b1;
                        end else begin
                            // fetch and write-back skip the peer
                            fwdValid     <= 1'b1;
                            peerModified <= 1'b0;
                        end
                    end
                end
                PROBE: begin
                    state <= SAMPLE;
                end
                SAMPLE: begin
                    // peer answers one edge after seeing the probe
                    peerModified <= coreReqs[peer].cctrans && coreReqs[peer].ccwrite;
                    fwdValid     <= 1'b1;
                    state        <= SNOOP_IDLE;
                end
                default: begin
                    state <= SNOOP_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        snoop.grant        = grant;
        snoop.grant.valid  = fwdValid;
        snoop.peerModified = peerModified;
    end

    // peer held in wait from the probe until completion
    always_comb begin
        for (int i = 0; i < nCores; i++) begin
            probeWait[i] = probing && (peer == coreIdx_t'(i));
            probeAddr[i] = probeWait[i] ? blockBase : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/requestArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module requestArbiter (
    input  logic                 CLK,
    input  logic                 nRST,
    input  memBusPkg::coreReq_t  coreReqs [memBusPkg::nCores],
    input  logic                 done,
    output coherencePkg::grant_t grant
);
    import memBusPkg::*;
    import coherencePkg::*;

    logic     busy;
    logic     pickValid;
    coreIdx_t pickCore;
    busOp_e   pickOp;
    word_t    pickAddr;
    word_t    pickStore;
    coreIdx_t grantCore;
    busOp_e   grantOp;
    word_t    grantAddr;
    word_t    grantStore;

    // scan lowest priority first so higher sources overwrite
    always_comb begin
        pickValid = 1'b0;
        pickCore  = '0;
        pickOp    = IFETCH;
        pickAddr  = '0;
        pickStore = '0;
        for (int i = nCores - 1; i >= 0; i--) begin
            if (coreReqs[i].iREN) begin
                pickValid = 1'b1;
                pickCore  = coreIdx_t'(i);
                pickOp    = IFETCH;
                pickAddr  = coreReqs[i].iaddr;
                pickStore = '0;
            end
        end
        for (int i = nCores - 1; i >= 0; i--) begin
            if (coreReqs[i].dWEN) begin
                pickValid = 1'b1;
                pickCore  = coreIdx_t'(i);
                pickOp    = DWRITEBACK;
                pickAddr  = coreReqs[i].daddr;
                pickStore = coreReqs[i].dstore;
            end
        end
        for (int i = nCores - 1; i >= 0; i--) begin
            if (coreReqs[i].dREN) begin
                pickValid = 1'b1;
                pickCore  = coreIdx_t'(i);
                // ccwrite with a read means read-exclusive
                if (coreReqs[i].ccwrite) begin
                    pickOp = BUSRDX;
                end else begin
                    pickOp = BUSRD;
                end
                pickAddr  = coreReqs[i].daddr;
                pickStore = coreReqs[i].dstore;
            end
        end
    end

    // busy from grant until done, so nothing new starts in between
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (!busy && pickValid) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && pickValid) begin
            grantCore  <= pickCore;
            grantOp    <= pickOp;
            grantAddr  <= pickAddr;
            grantStore <= pickStore;
        end
    end

    always_comb begin
        grant.valid = busy;
        grant.core  = grantCore;
        grant.op    = grantOp;
        grant.addr  = grantAddr;
        grant.store = grantStore;
    end

endmodule

`default_nettype wire

/* verilog/coherencePkg.sv */
`default_nettype none

package coherencePkg;

    localparam int coreBits = $clog2(memBusPkg::nCores);

    typedef logic [coreBits-1:0] coreIdx_t;

    typedef enum logic [1:0] {
        IFETCH,
        DWRITEBACK,
        BUSRD,
        BUSRDX
    } busOp_e;

    // one granted request, held until the sequencer completes it
    typedef struct packed {
        logic             valid;
        coreIdx_t         core;
        busOp_e           op;
        memBusPkg::word_t addr;
        memBusPkg::word_t store;
    } grant_t;

    typedef struct packed {
        grant_t grant;
        logic   peerModified;
    } snoopResult_t;

    typedef enum logic [1:0] {
        SNOOP_IDLE,
        PROBE,
        SAMPLE
    } snoopState_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        PEERWB0,
        PEERWB1,
        TRANSFER
    } seqState_e;

endpackage

`default_nettype wire

/* verilog/memBusPkg.sv */
`default_nettype none

package memBusPkg;

    localparam int wordBits = 32;
    localparam int nCores = 2;
    // byte step between the words of a block
    localparam int wordBytes = 4;
    localparam int blockWords = 2;

    typedef logic [wordBits-1:0] word_t;

    // ACCESS marks the cycle in which the current access completes
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramState_e;

    typedef struct packed {
        logic  iREN;
        logic  dREN;
        logic  dWEN;
        word_t iaddr;
        word_t daddr;
        word_t dstore;
        // snoop hit
        logic  cctrans;
        // modified on a snoop, or intent to write on a request
        logic  ccwrite;
    } coreReq_t;

    typedef struct packed {
        logic  iwait;
        logic  dwait;
        word_t iload;
        word_t dload;
        logic  ccwait;
        logic  ccinv;
        word_t ccsnoopaddr;
    } coreResp_t;

    typedef struct packed {
        logic  ramREN;
        logic  ramWEN;
        word_t ramaddr;
        word_t ramstore;
    } ramReq_t;

    typedef struct packed {
        word_t     ramload;
        ramState_e ramstate;
    } ramResp_t;

endpackage

`default_nettype wire
